// ==== exec_defs.svh ====
// ------------------------------------------------------------
// Execution subsystem sizing macros
// Data width, issue port count and multiply step count
// ------------------------------------------------------------
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Width of operands and results
`define XLEN 32

// Issue slots sharing the one ALU
`define NUM_PORTS 2

// One shift-and-add step per multiplier bit
`define MUL_STEPS `XLEN

`endif

// ==== alu_pkg.sv ====
// ------------------------------------------------------------
// ALU types
// Operation codes and the data word shared by the datapath
// ------------------------------------------------------------
`include "exec_defs.svh"

package alu_pkg;

  // Operand and result word
  typedef logic [`XLEN-1:0] word_t;

  // Two-bit operation code, encoding follows the issue slot format
  typedef enum logic [1:0]
  {
    op_add = 2'd0,
    op_sub = 2'd1,
    op_mul = 2'd2,
    op_and = 2'd3
  } alu_op_t;

endpackage

// ==== port_pkg.sv ====
// ------------------------------------------------------------
// Issue port types
// Port index and arbiter phase used by the ALU arbiter
// ------------------------------------------------------------
`include "exec_defs.svh"

package port_pkg;

  // Index of one issue slot
  typedef logic [$clog2(`NUM_PORTS)-1:0] port_id_t;

  // Phases of one granted transaction
  typedef enum logic [1:0]
  {
    arb_idle,
    arb_busy,
    arb_hold
  } arb_state_t;

endpackage

// ==== shift_add_multiplier.sv ====
// ------------------------------------------------------------
// Shift-and-add multiplier
// Iterative, one multiplier bit per cycle, returns the low
// word of the product with a single-cycle done pulse
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "exec_defs.svh"

module shift_add_multiplier
(
  input  logic           clk,
  input  logic           reset,
  input  logic           mul_start,
  input  alu_pkg::word_t mul_a,
  input  alu_pkg::word_t mul_b,
  output alu_pkg::word_t mul_product,
  output logic           mul_done
);

  import alu_pkg::*;

  // Multiplicand shifts left, multiplier shifts right
  word_t mcand;
  word_t mplier;
  word_t acc;

  // Steps still to run, zero when idle
  logic [$clog2(`MUL_STEPS+1)-1:0] steps_left;
  logic busy;

  // Control state
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy       <= 1'b0;
      steps_left <= '0;
      mul_done   <= 1'b0;
    end
    else
    begin
      mul_done <= 1'b0;
      if (mul_start)
      begin
        busy       <= 1'b1;
        steps_left <= ($clog2(`MUL_STEPS+1))'(`MUL_STEPS);
      end
      else if (busy)
      begin
        steps_left <= steps_left - 1'b1;
        // Last step, done shows up with the final product
        if (steps_left == 1)
        begin
          busy     <= 1'b0;
          mul_done <= 1'b1;
        end
      end
    end
  end

  // Datapath, bits above XLEN simply fall off
  always_ff @(posedge clk)
  begin
    if (mul_start)
    begin
      acc    <= '0;
      mcand  <= mul_a;
      mplier <= mul_b;
    end
    else if (busy)
    begin
      if (mplier[0])
        acc <= acc + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign mul_product = acc;

endmodule

// ==== alu.sv ====
// ------------------------------------------------------------
// Integer ALU
// Single-cycle add, sub and AND, multi-cycle multiply via the
// shift-and-add unit; registers result, zero flag and done
// ------------------------------------------------------------
`timescale 1ns/1ps

module alu
(
  input  logic             clk,
  input  logic             reset,
  input  logic             alu_start,
  input  alu_pkg::alu_op_t alu_op,
  input  alu_pkg::word_t   alu_a,
  input  alu_pkg::word_t   alu_b,
  output alu_pkg::word_t   alu_result,
  output logic             alu_zero,
  output logic             alu_done
);

  import alu_pkg::*;

  // Shared adder inputs
  logic  carry_in;
  word_t addend;
  word_t sum;

  // Result of the single-cycle operations
  word_t quick_result;
  logic  quick_op;

  // Multiplier hookup
  logic  mul_start;
  word_t mul_a;
  word_t mul_b;
  word_t mul_product;
  logic  mul_done;

  // Subtract is a + ~b + 1 on the same adder
  assign carry_in = (alu_op == op_sub);
  assign addend   = carry_in ? ~alu_b : alu_b;
  assign sum      = alu_a + addend + word_t'(carry_in);

  always_comb
  begin
    case (alu_op)
      op_and:  quick_result = alu_a & alu_b;
      default: quick_result = sum;
    endcase
  end

  // Everything except mul completes on the start edge
  assign quick_op = (alu_op != op_mul);

  // Operands stay stable until done, so they feed the multiplier directly
  assign mul_start = alu_start && !quick_op;
  assign mul_a     = alu_a;
  assign mul_b     = alu_b;

  shift_add_multiplier u_mul
  (
    .clk         (clk),
    .reset       (reset),
    .mul_start   (mul_start),
    .mul_a       (mul_a),
    .mul_b       (mul_b),
    .mul_product (mul_product),
    .mul_done    (mul_done)
  );

  // Done pulse, one cycle after start or after the multiplier finishes
  always_ff @(posedge clk)
  begin
    if (reset)
      alu_done <= 1'b0;
    else
      alu_done <= (alu_start && quick_op) || mul_done;
  end

  // Zero flag is the result itself compared with zero
  always_ff @(posedge clk)
  begin
    if (alu_start && quick_op)
    begin
      alu_result <= quick_result;
      alu_zero   <= (quick_result == '0);
    end
    else if (mul_done)
    begin
      alu_result <= mul_product;
      alu_zero   <= (mul_product == '0);
    end
  end

endmodule

// ==== alu_arbiter.sv ====
// ------------------------------------------------------------
// ALU arbiter
// Round-robin grant of the shared ALU to the issue ports,
// ack side of the four-phase req/ack handshake per port
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "exec_defs.svh"

module alu_arbiter
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`NUM_PORTS-1:0]  req,
  input  alu_pkg::alu_op_t       op [`NUM_PORTS],
  input  alu_pkg::word_t         operand_a [`NUM_PORTS],
  input  alu_pkg::word_t         operand_b [`NUM_PORTS],
  input  alu_pkg::word_t         alu_result,
  input  logic                   alu_zero,
  input  logic                   alu_done,
  output logic [`NUM_PORTS-1:0]  ack,
  output alu_pkg::word_t         result [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0]  zero,
  output logic                   alu_start,
  output alu_pkg::alu_op_t       alu_op,
  output alu_pkg::word_t         alu_a,
  output alu_pkg::word_t         alu_b
);

  import alu_pkg::*;
  import port_pkg::*;

  arb_state_t state;

  // Port currently owning the ALU
  port_id_t grant;
  // Port with first claim on the next grant
  port_id_t rr_ptr;

  // Idle-phase pick
  logic     pick_valid;
  port_id_t pick_id;

  // Scan from the favoured port onwards, lowest offset wins
  always_comb
  begin
    port_id_t idx;
    pick_valid = 1'b0;
    pick_id    = rr_ptr;
    for (int i = `NUM_PORTS - 1; i >= 0; i--)
    begin
      idx = port_id_t'(rr_ptr + i);
      if (req[idx])
      begin
        pick_valid = 1'b1;
        pick_id    = idx;
      end
    end
  end

  // Handshake FSM
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= arb_idle;
      grant     <= '0;
      rr_ptr    <= '0;
      ack       <= '0;
      alu_start <= 1'b0;
    end
    else
    begin
      alu_start <= 1'b0;
      case (state)
        arb_idle:
          if (pick_valid)
          begin
            grant     <= pick_id;
            // Other port goes first next time
            rr_ptr    <= port_id_t'(pick_id + 1'b1);
            alu_start <= 1'b1;
            state     <= arb_busy;
          end
        arb_busy:
          // Result is latched on this same edge
          if (alu_done)
          begin
            ack[grant] <= 1'b1;
            state      <= arb_hold;
          end
        arb_hold:
          // Requester dropped req, close the handshake
          if (!req[grant])
          begin
            ack[grant] <= 1'b0;
            state      <= arb_idle;
          end
        default:
          state <= arb_idle;
      endcase
    end
  end

  // Operation to the ALU, held until done
  always_ff @(posedge clk)
  begin
    if (state == arb_idle && pick_valid)
    begin
      alu_op <= op[pick_id];
      alu_a  <= operand_a[pick_id];
      alu_b  <= operand_b[pick_id];
    end
  end

  // Per-port result, kept after ack falls
  always_ff @(posedge clk)
  begin
    if (state == arb_busy && alu_done)
    begin
      result[grant] <= alu_result;
      zero[grant]   <= alu_zero;
    end
  end

endmodule

// ==== exec_unit.sv ====
// ------------------------------------------------------------
// Integer execution unit
// Two issue ports sharing one ALU through the arbiter
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_unit
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`NUM_PORTS-1:0] req,
  input  alu_pkg::alu_op_t      op [`NUM_PORTS],
  input  alu_pkg::word_t        operand_a [`NUM_PORTS],
  input  alu_pkg::word_t        operand_b [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0] ack,
  output alu_pkg::word_t        result [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0] zero
);

  import alu_pkg::*;

  // Arbiter to ALU
  logic    alu_start;
  alu_op_t alu_op;
  word_t   alu_a;
  word_t   alu_b;

  // ALU back to arbiter
  word_t   alu_result;
  logic    alu_zero;
  logic    alu_done;

  alu_arbiter u_arbiter
  (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .op         (op),
    .operand_a  (operand_a),
    .operand_b  (operand_b),
    .alu_result (alu_result),
    .alu_zero   (alu_zero),
    .alu_done   (alu_done),
    .ack        (ack),
    .result     (result),
    .zero       (zero),
    .alu_start  (alu_start),
    .alu_op     (alu_op),
    .alu_a      (alu_a),
    .alu_b      (alu_b)
  );

  alu u_alu
  (
    .clk        (clk),
    .reset      (reset),
    .alu_start  (alu_start),
    .alu_op     (alu_op),
    .alu_a      (alu_a),
    .alu_b      (alu_b),
    .alu_result (alu_result),
    .alu_zero   (alu_zero),
    .alu_done   (alu_done)
  );

endmodule

// ==== tb_exec_unit.sv ====
// ------------------------------------------------------------
// Testbench for the integer execution unit
// LFSR stimulus on both issue ports, reference model and
// four-phase handshake checks
// ------------------------------------------------------------
`timescale 1ns/1ps
`include "exec_defs.svh"

module tb_exec_unit;

  import alu_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int N_SINGLE     = 40;
  localparam int N_MUL        = 12;
  localparam int N_DUAL       = 10;
  localparam int TOTAL_OPS    = N_SINGLE + N_MUL + `NUM_PORTS * N_DUAL;
  // Worst case per op is a full multiply plus handshake and hold slack
  localparam int TIMEOUT_CYCLES = TOTAL_OPS * (`MUL_STEPS + 8) + RESET_CYCLES;

  logic                  clk;
  logic                  reset;
  logic [`NUM_PORTS-1:0] req;
  alu_op_t               op [`NUM_PORTS];
  word_t                 operand_a [`NUM_PORTS];
  word_t                 operand_b [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] ack;
  word_t                 result [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] zero;

  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;
  logic [31:0] lfsr_state  = 32'hd21d_87ff;
  // Port ids in the order their ack rose
  int          ack_order [$];
  logic [`NUM_PORTS-1:0] prev_ack;

  // Per-port stimulus for the shared test is made before the fork
  alu_op_t dual_op [`NUM_PORTS][N_DUAL];
  word_t   dual_a [`NUM_PORTS][N_DUAL];
  word_t   dual_b [`NUM_PORTS][N_DUAL];
  int      dual_hold [`NUM_PORTS][N_DUAL];

  exec_unit u_dut
  (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .op        (op),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .ack       (ack),
    .result    (result),
    .zero      (zero)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
    cycle_count <= cycle_count + 1;

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // Reference model where all results wrap modulo 2^XLEN
  function automatic word_t model_result(input alu_op_t o, input word_t a, input word_t b);
    case (o)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_mul:  return a * b;
      default: return a & b;
    endcase
  endfunction

  task automatic report_value(input string name, input word_t exp_v, input word_t act_v);
    error_count++;
    $display("Fail %s: expected %h actual %h", name, exp_v, act_v);
  endtask

  task automatic report_text(input string msg);
    error_count++;
    $display("Error: %s", msg);
  endtask

  // Sample and drive 5 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  // One full four-phase transaction on port p
  task automatic run_op(input int p, input alu_op_t o, input word_t a, input word_t b,
                        input int hold, input string name);
    word_t exp_res;
    logic  exp_zero;
    exp_res  = model_result(o, a, b);
    exp_zero = (exp_res == '0);
    op[p]        = o;
    operand_a[p] = a;
    operand_b[p] = b;
    req[p]       = 1'b1;
    do
      next_cycle();
    while (!ack[p]);
    check_count += 2;
    if (result[p] !== exp_res)
      report_value(name, exp_res, result[p]);
    if (zero[p] !== exp_zero)
      report_value({name, " zero"}, word_t'(exp_zero), word_t'(zero[p]));
    // Ack and result must not move while the requester keeps req up
    repeat (hold)
    begin
      next_cycle();
      check_count++;
      if (ack[p] !== 1'b1)
        report_text($sformatf("%s: ack fell on port %0d while req was high", name, p));
      if (result[p] !== exp_res)
        report_value({name, " hold"}, exp_res, result[p]);
    end
    req[p] = 1'b0;
    do
      next_cycle();
    while (ack[p]);
    // Result stays put after the handshake closes
    check_count++;
    if (result[p] !== exp_res)
      report_value({name, " after ack"}, exp_res, result[p]);
  endtask

  // Ack monitor looking just after each edge
  initial
  begin
    prev_ack = '0;
    forever
    begin
      @(posedge clk);
      #1;
      for (int i = 0; i < `NUM_PORTS; i++)
      begin
        if (ack[i] === 1'b1 && prev_ack[i] !== 1'b1)
        begin
          if (req[i] !== 1'b1)
            report_text($sformatf("ack rose on port %0d while req was low", i));
          ack_order.push_back(i);
        end
      end
      prev_ack = ack;
    end
  end

  // Run limit
  initial
  begin
    while (cycle_count < TIMEOUT_CYCLES)
      @(posedge clk);
    $display("Timeout: no progress within %0d cycles", TIMEOUT_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    alu_op_t o;
    word_t   a;
    word_t   b;
    logic [1:0] sel;
    reset = 1'b1;
    req   = '0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      op[p]        = op_add;
      operand_a[p] = '0;
      operand_b[p] = '0;
    end
    repeat (RESET_CYCLES) next_cycle();
    reset = 1'b0;

    // No req after reset so no ack
    repeat (4)
    begin
      next_cycle();
      check_count++;
      if (ack !== '0)
        report_value("idle ack", '0, word_t'(ack));
    end

    // Single-cycle ops on port 0 with zero and overflow corners
    for (int k = 0; k < N_SINGLE; k++)
    begin
      sel = 2'(rand_bits(2));
      a   = rand_bits(`XLEN);
      b   = rand_bits(`XLEN);
      o   = alu_op_t'(rand_bits(2));
      if (o == op_mul)
        o = op_add;
      case (sel)
        2'd0:
        begin
          o = op_sub;
          b = a;
        end
        2'd1:
        begin
          o = op_and;
          b = ~a;
        end
        2'd2:
        begin
          // Both top bits set so the sum wraps
          o = op_add;
          a = a | 32'h8000_0000;
          b = b | 32'h8000_0000;
        end
        default:
        begin
        end
      endcase
      run_op(0, o, a, b, int'(rand_bits(2)), "single");
    end

    // Multiply with zero operands and large operands
    for (int k = 0; k < N_MUL; k++)
    begin
      a = rand_bits(`XLEN);
      b = rand_bits(`XLEN);
      case (k % 4)
        0: a = '0;
        1: b = '0;
        2:
        begin
          a = a | 32'hc000_0000;
          b = b | 32'hc000_0000;
        end
        default:
        begin
        end
      endcase
      run_op(0, op_mul, a, b, int'(rand_bits(2)), "mul");
    end

    // Both ports at once with independent streams
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      for (int k = 0; k < N_DUAL; k++)
      begin
        dual_op[p][k]   = alu_op_t'(rand_bits(2));
        dual_a[p][k]    = rand_bits(`XLEN);
        dual_b[p][k]    = rand_bits(`XLEN);
        dual_hold[p][k] = int'(rand_bits(2));
      end
    end
    ack_order.delete();
    fork
      begin
        for (int k = 0; k < N_DUAL; k++)
          run_op(0, dual_op[0][k], dual_a[0][k], dual_b[0][k], dual_hold[0][k], "dual p0");
      end
      begin
        for (int k = 0; k < N_DUAL; k++)
          run_op(1, dual_op[1][k], dual_a[1][k], dual_b[1][k], dual_hold[1][k], "dual p1");
      end
    join

    // Every request is served and grants alternate
    check_count++;
    if (ack_order.size() != `NUM_PORTS * N_DUAL)
      report_value("dual count", `NUM_PORTS * N_DUAL, ack_order.size());
    for (int i = 1; i < ack_order.size(); i++)
    begin
      check_count++;
      if (ack_order[i] == ack_order[i-1])
        report_text($sformatf("port %0d granted twice in a row", ack_order[i]));
    end

    next_cycle();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+.
alu_pkg.sv
port_pkg.sv
shift_add_multiplier.sv
alu.sv
alu_arbiter.sv
exec_unit.sv
tb_exec_unit.sv

// ==== Makefile ====
# Verilator build and run of the execution unit testbench

TOP := tb_exec_unit

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -j 0 -f verilog.f --top-module $(TOP) -Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '>>> PASS'

clean:
	rm -rf obj_dir
